//--- Makefile
TOOL     = verilator
FLAGS    = --binary --timing --timescale 1ns/1ns
TOP      = tb_decoding_graph
FILELIST = list.f
BUILD    = obj_dir

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build folder"
	@echo "  help   show this list"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD)
	./$(BUILD)/V$(TOP)

clean:
	rm -rf $(BUILD)

//--- list.f
+incdir+testbench
src/decoder_pkg.sv
src/vertex_array.sv
src/link_array.sv
src/cluster_parity.sv
src/decoding_graph.sv
testbench/tb_decoding_graph.sv

//--- src/cluster_parity.sv
`timescale 1ns/1ns

module cluster_parity (
    input  decoder_pkg::pu_bits_t  defects_i,
    input  decoder_pkg::root_vec_t roots_i,
    input  decoder_pkg::pu_bits_t  boundary_touch_i,
    output decoder_pkg::pu_bits_t  odd_clusters_o
);

    decoder_pkg::pu_bits_t parity;  // defect count of the cluster, mod 2
    decoder_pkg::pu_bits_t touch;   // cluster reaches a boundary

    // units with the same root are in the same cluster
    always_comb begin
        parity = '0;
        touch  = '0;
        for (int p = 0; p < decoder_pkg::PU_COUNT; p++) begin
            for (int q = 0; q < decoder_pkg::PU_COUNT; q++) begin
                if (roots_i[p*decoder_pkg::ADDRESS_WIDTH +: decoder_pkg::ADDRESS_WIDTH] ==
                    roots_i[q*decoder_pkg::ADDRESS_WIDTH +: decoder_pkg::ADDRESS_WIDTH]) begin
                    parity[p] = parity[p] ^ defects_i[q];
                    touch[p]  = touch[p] | boundary_touch_i[q];
                end
            end
        end
    end

    // odd and still isolated from any boundary
    assign odd_clusters_o = parity & ~touch;

endmodule

//--- src/decoder_pkg.sv
package decoder_pkg;

    // grid geometry
    localparam int GRID_WIDTH_X = 4;   // detectors per round
    localparam int GRID_WIDTH_U = 3;   // rounds held in the graph

    localparam int X_BIT_WIDTH   = $clog2(GRID_WIDTH_X);
    localparam int U_BIT_WIDTH   = $clog2(GRID_WIDTH_U);
    localparam int ADDRESS_WIDTH = X_BIT_WIDTH + U_BIT_WIDTH;

    localparam int PU_COUNT = GRID_WIDTH_X * GRID_WIDTH_U;

    // link 0 is the west boundary and link GRID_WIDTH_X the east one
    localparam int ROW_LINK_COUNT   = GRID_WIDTH_X + 1;
    localparam int ROUND_LINK_COUNT = GRID_WIDTH_X * (GRID_WIDTH_U - 1);
    localparam int ERASURE_WIDTH    = GRID_WIDTH_X - 1;  // internal row links only

    // growth counters
    localparam int LINK_BIT_WIDTH = 2;
    localparam logic [LINK_BIT_WIDTH-1:0] LINK_WEIGHT = 2'd2;

    // round in upper bits, column in lower bits
    typedef logic [ADDRESS_WIDTH-1:0] addr_t;

    typedef logic [GRID_WIDTH_X-1:0]  round_bits_t;
    typedef logic [ERASURE_WIDTH-1:0] erasure_bits_t;
    typedef logic [PU_COUNT-1:0]      pu_bits_t;

    // unit 0 in the lowest slice
    typedef logic [PU_COUNT*ADDRESS_WIDTH-1:0] root_vec_t;

    typedef logic [GRID_WIDTH_U*ROW_LINK_COUNT-1:0] row_link_bits_t;
    typedef logic [ROUND_LINK_COUNT-1:0]            round_link_bits_t;

    // broadcast from the outside controller
    typedef enum logic [1:0] {
        STAGE_IDLE,
        STAGE_LOAD,
        STAGE_GROW,
        STAGE_MERGE
    } stage_t;

endpackage

//--- src/decoding_graph.sv
`timescale 1ns/1ns

module decoding_graph (
    input  logic                       clk,
    input  logic                       rst_n_i,
    input  decoder_pkg::stage_t        global_stage_i,
    input  decoder_pkg::round_bits_t   measurements_i,
    input  decoder_pkg::erasure_bits_t erasure_i,
    output decoder_pkg::pu_bits_t      odd_clusters_o,
    output decoder_pkg::root_vec_t     roots_o,
    output logic                       busy_o
);

    decoder_pkg::pu_bits_t         defects;
    decoder_pkg::root_vec_t        roots;
    decoder_pkg::pu_bits_t         odd_clusters;  // feeds growth back
    decoder_pkg::pu_bits_t         boundary_touch;
    decoder_pkg::row_link_bits_t   row_full;
    decoder_pkg::round_link_bits_t round_full;
    logic                          busy;

    // defects, roots and the merge step
    vertex_array u_vertex_array (
        .clk            (clk),
        .rst_n_i        (rst_n_i),
        .global_stage_i (global_stage_i),
        .measurements_i (measurements_i),
        .row_full_i     (row_full),
        .round_full_i   (round_full),
        .defects_o      (defects),
        .roots_o        (roots),
        .busy_o         (busy)
    );

    // growth counters and erasure chain
    link_array u_link_array (
        .clk              (clk),
        .rst_n_i          (rst_n_i),
        .global_stage_i   (global_stage_i),
        .erasure_i        (erasure_i),
        .odd_clusters_i   (odd_clusters),
        .row_full_o       (row_full),
        .round_full_o     (round_full),
        .boundary_touch_o (boundary_touch)
    );

    // only meaningful once the merge has settled
    cluster_parity u_cluster_parity (
        .defects_i        (defects),
        .roots_i          (roots),
        .boundary_touch_i (boundary_touch),
        .odd_clusters_o   (odd_clusters)
    );

    assign odd_clusters_o = odd_clusters;
    assign roots_o        = roots;
    assign busy_o         = busy;

endmodule

//--- src/link_array.sv
`timescale 1ns/1ns

module link_array (
    input  logic                          clk,
    input  logic                          rst_n_i,
    input  decoder_pkg::stage_t           global_stage_i,
    input  decoder_pkg::erasure_bits_t    erasure_i,
    input  decoder_pkg::pu_bits_t         odd_clusters_i,
    output decoder_pkg::row_link_bits_t   row_full_o,
    output decoder_pkg::round_link_bits_t round_full_o,
    output decoder_pkg::pu_bits_t         boundary_touch_o
);

    // erasure state of rounds 1 and up
    decoder_pkg::erasure_bits_t erased_q [1:decoder_pkg::GRID_WIDTH_U-1];

    logic load;
    logic grow;

    assign load = global_stage_i == decoder_pkg::STAGE_LOAD;
    assign grow = global_stage_i == decoder_pkg::STAGE_GROW;

    // add one per odd endpoint and stop at the weight
    function automatic logic [decoder_pkg::LINK_BIT_WIDTH-1:0] grow_count(
        input logic [decoder_pkg::LINK_BIT_WIDTH-1:0] count,
        input logic                                   odd_a,
        input logic                                   odd_b
    );
        logic [decoder_pkg::LINK_BIT_WIDTH:0] inc_a;
        logic [decoder_pkg::LINK_BIT_WIDTH:0] inc_b;
        logic [decoder_pkg::LINK_BIT_WIDTH:0] sum;
        inc_a    = '0;
        inc_a[0] = odd_a;
        inc_b    = '0;
        inc_b[0] = odd_b;
        sum      = {1'b0, count} + inc_a + inc_b;
        if (sum >= {1'b0, decoder_pkg::LINK_WEIGHT}) begin
            return decoder_pkg::LINK_WEIGHT;
        end
        return sum[decoder_pkg::LINK_BIT_WIDTH-1:0];
    endfunction

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            for (int k = 1; k < decoder_pkg::GRID_WIDTH_U; k++) begin
                erased_q[k] <= '0;
            end
        end else if (load) begin
            erased_q[decoder_pkg::GRID_WIDTH_U-1] <= erasure_i;
            for (int k = 1; k < decoder_pkg::GRID_WIDTH_U - 1; k++) begin
                erased_q[k] <= erased_q[k+1];  // moves down with its round
            end
        end
    end

    // boundary row links have a single endpoint
    for (genvar k = 0; k < decoder_pkg::GRID_WIDTH_U; k++) begin : g_row_round
        for (genvar j = 0; j < decoder_pkg::ROW_LINK_COUNT; j++) begin : g_row_link
            localparam int L = k * decoder_pkg::ROW_LINK_COUNT + j;
            localparam int UNIT_BASE = k * decoder_pkg::GRID_WIDTH_X;

            logic [decoder_pkg::LINK_BIT_WIDTH-1:0] count_q;
            logic odd_w;
            logic odd_e;
            logic preset;  // erased link of the round being loaded

            if (j > 0) begin : g_w
                assign odd_w = odd_clusters_i[UNIT_BASE + j - 1];
            end else begin : g_w_none
                assign odd_w = 1'b0;
            end

            if (j < decoder_pkg::GRID_WIDTH_X) begin : g_e
                assign odd_e = odd_clusters_i[UNIT_BASE + j];
            end else begin : g_e_none
                assign odd_e = 1'b0;
            end

            if (j > 0 && j < decoder_pkg::GRID_WIDTH_X) begin : g_internal
                if (k == decoder_pkg::GRID_WIDTH_U - 1) begin : g_top
                    assign preset = erasure_i[j-1];
                end else begin : g_lower
                    assign preset = erased_q[k+1][j-1];
                end
            end else begin : g_boundary
                assign preset = 1'b0;
            end

            always_ff @(posedge clk) begin
                if (!rst_n_i) begin
                    count_q <= '0;
                end else if (load) begin
                    count_q <= preset ? decoder_pkg::LINK_WEIGHT : '0;
                end else if (grow) begin
                    count_q <= grow_count(count_q, odd_w, odd_e);
                end
            end

            assign row_full_o[L] = count_q == decoder_pkg::LINK_WEIGHT;
        end
    end

    // link L joins unit L with the unit one round above
    for (genvar l = 0; l < decoder_pkg::ROUND_LINK_COUNT; l++) begin : g_round_link
        logic [decoder_pkg::LINK_BIT_WIDTH-1:0] count_q;

        always_ff @(posedge clk) begin
            if (!rst_n_i || load) begin
                count_q <= '0;  // never erased
            end else if (grow) begin
                count_q <= grow_count(count_q, odd_clusters_i[l],
                                      odd_clusters_i[l + decoder_pkg::GRID_WIDTH_X]);
            end
        end

        assign round_full_o[l] = count_q == decoder_pkg::LINK_WEIGHT;
    end

    // edge columns see their boundary link
    for (genvar k = 0; k < decoder_pkg::GRID_WIDTH_U; k++) begin : g_touch_round
        for (genvar i = 0; i < decoder_pkg::GRID_WIDTH_X; i++) begin : g_touch_col
            localparam int ROW_BASE = k * decoder_pkg::ROW_LINK_COUNT;
            assign boundary_touch_o[k*decoder_pkg::GRID_WIDTH_X + i] =
                (i == 0 && row_full_o[ROW_BASE]) ||
                (i == decoder_pkg::GRID_WIDTH_X - 1 &&
                 row_full_o[ROW_BASE + decoder_pkg::GRID_WIDTH_X]);
        end
    end

endmodule

//--- src/vertex_array.sv
`timescale 1ns/1ns

module vertex_array (
    input  logic                          clk,
    input  logic                          rst_n_i,
    input  decoder_pkg::stage_t           global_stage_i,
    input  decoder_pkg::round_bits_t      measurements_i,
    input  decoder_pkg::row_link_bits_t   row_full_i,
    input  decoder_pkg::round_link_bits_t round_full_i,
    output decoder_pkg::pu_bits_t         defects_o,
    output decoder_pkg::root_vec_t        roots_o,
    output logic                          busy_o
);

    decoder_pkg::pu_bits_t defects_q;   // round k in bits [k*X +: X]
    decoder_pkg::addr_t    root_q    [decoder_pkg::PU_COUNT];
    decoder_pkg::addr_t    root_next [decoder_pkg::PU_COUNT];
    decoder_pkg::pu_bits_t root_changed;
    logic                  busy_q;

    function automatic decoder_pkg::addr_t min_addr(
        input decoder_pkg::addr_t a,
        input decoder_pkg::addr_t b
    );
        return (b < a) ? b : a;
    endfunction

    // one minimum exchange step per unit
    for (genvar k = 0; k < decoder_pkg::GRID_WIDTH_U; k++) begin : g_round
        for (genvar i = 0; i < decoder_pkg::GRID_WIDTH_X; i++) begin : g_col
            localparam int P = k * decoder_pkg::GRID_WIDTH_X + i;
            localparam int ROW_BASE = k * decoder_pkg::ROW_LINK_COUNT;

            decoder_pkg::addr_t own_root;
            decoder_pkg::addr_t west_root;
            decoder_pkg::addr_t east_root;
            decoder_pkg::addr_t down_root;
            decoder_pkg::addr_t up_root;

            assign own_root = root_q[P];

            // a missing or ungrown neighbor falls back to the own root
            if (i > 0) begin : g_west
                assign west_root = row_full_i[ROW_BASE + i] ? root_q[P-1] : own_root;
            end else begin : g_west_edge
                assign west_root = own_root;  // west boundary never joins
            end

            if (i < decoder_pkg::GRID_WIDTH_X - 1) begin : g_east
                assign east_root = row_full_i[ROW_BASE + i + 1] ? root_q[P+1] : own_root;
            end else begin : g_east_edge
                assign east_root = own_root;
            end

            if (k > 0) begin : g_down
                assign down_root = round_full_i[P - decoder_pkg::GRID_WIDTH_X] ?
                                   root_q[P - decoder_pkg::GRID_WIDTH_X] : own_root;
            end else begin : g_down_edge
                assign down_root = own_root;
            end

            if (k < decoder_pkg::GRID_WIDTH_U - 1) begin : g_up
                assign up_root = round_full_i[P] ?
                                 root_q[P + decoder_pkg::GRID_WIDTH_X] : own_root;
            end else begin : g_up_edge
                assign up_root = own_root;
            end

            assign root_next[P] = min_addr(min_addr(own_root, west_root),
                                           min_addr(min_addr(east_root, down_root), up_root));
            assign root_changed[P] = root_next[P] != own_root;

            assign roots_o[P*decoder_pkg::ADDRESS_WIDTH +: decoder_pkg::ADDRESS_WIDTH] = own_root;
        end
    end

    // measurements enter at the top round and move down one round per load
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            defects_q <= '0;
        end else if (global_stage_i == decoder_pkg::STAGE_LOAD) begin
            defects_q <= {measurements_i,
                          defects_q[decoder_pkg::PU_COUNT-1:decoder_pkg::GRID_WIDTH_X]};
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            for (int p = 0; p < decoder_pkg::PU_COUNT; p++) begin
                root_q[p] <= decoder_pkg::addr_t'(p);
            end
        end else if (global_stage_i == decoder_pkg::STAGE_LOAD) begin
            for (int p = 0; p < decoder_pkg::PU_COUNT; p++) begin
                root_q[p] <= decoder_pkg::addr_t'(p);  // fresh singletons
            end
        end else if (global_stage_i == decoder_pkg::STAGE_MERGE) begin
            root_q <= root_next;
        end
    end

    // low one edge after the roots settle or the stage leaves merge
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            busy_q <= 1'b0;
        end else begin
            busy_q <= (global_stage_i == decoder_pkg::STAGE_MERGE) && (|root_changed);
        end
    end

    assign defects_o = defects_q;
    assign busy_o    = busy_q;

endmodule

//--- testbench/tb_tasks.svh
task automatic check_value(
    input string       name,
    input logic [63:0] got,
    input logic [63:0] expected
);
    if (got !== expected) begin
        $display("ERROR %s: got 0x%0h, expected 0x%0h", name, got, expected);
        $display("TESTBENCH FAILED");
        $fatal(1, "value mismatch");
    end
endtask

function automatic int unsigned lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state >> 16;  // upper bits are the better ones
endfunction

function automatic decoder_pkg::addr_t root_at(input int p);
    return roots_o[p*AW +: AW];
endfunction

// entered and left on a falling edge
task automatic hold_stage(input decoder_pkg::stage_t stage, input int cycles);
    global_stage = stage;
    repeat (cycles) @(negedge clk);
    global_stage = decoder_pkg::STAGE_IDLE;
endtask

task automatic load_round(
    input decoder_pkg::round_bits_t   meas,
    input decoder_pkg::erasure_bits_t er
);
    measurements = meas;
    erasure      = er;
    hold_stage(decoder_pkg::STAGE_LOAD, 1);
    measurements = '0;
    erasure      = '0;
    shift_in_round(meas, er);
endtask

task automatic grow_steps(input int steps);
    repeat (steps) begin
        hold_stage(decoder_pkg::STAGE_GROW, 1);
        grow_links();
    end
endtask

// at least one edge, then until busy drops
task automatic merge_until_idle();
    int edges;
    global_stage = decoder_pkg::STAGE_MERGE;
    @(negedge clk);
    edges = 1;
    while (busy_o) begin
        if (edges >= decoder_pkg::PU_COUNT) begin
            $display("merge still busy after %0d clock edges", edges);
            $display("TESTBENCH FAILED");
            $fatal(1, "merge did not converge");
        end else begin
            @(negedge clk);
            edges++;
        end
    end
    global_stage = decoder_pkg::STAGE_IDLE;
    merge_clusters();
endtask

task automatic compare_outputs();
    check_value("roots_o", 64'(roots_o), 64'(packed_roots()));
    check_value("odd_clusters_o", 64'(odd_clusters_o), 64'(odd_flags()));
endtask

task automatic after_reset_check();
    check_value("busy_o", 64'(busy_o), 64'd0);
    check_value("odd_clusters_o", 64'(odd_clusters_o), 64'd0);
    for (int p = 0; p < decoder_pkg::PU_COUNT; p++) begin
        check_value("roots_o", 64'(root_at(p)), 64'(p));
    end
endtask

// first pattern ends up in round 0
task automatic load_and_shift();
    load_round(4'b0101, 3'b000);
    load_round(4'b1010, 3'b000);
    load_round(4'b0110, 3'b000);
    merge_until_idle();
    check_value("odd_clusters_o", 64'(odd_clusters_o), 64'(12'b0110_1010_0101));
    for (int p = 0; p < decoder_pkg::PU_COUNT; p++) begin
        check_value("roots_o", 64'(root_at(p)), 64'(p));
    end
    compare_outputs();
endtask

task automatic growth_and_merge();
    load_round(4'b0100, 3'b000);  // lone defect at unit 2
    load_round(4'b0000, 3'b000);
    load_round(4'b0110, 3'b000);  // pair at units 9 and 10
    grow_steps(1);
    merge_until_idle();
    check_value("roots_o[9]", 64'(root_at(9)), 64'd9);
    check_value("roots_o[10]", 64'(root_at(10)), 64'd9);
    check_value("odd_clusters_o[9]", 64'(odd_clusters_o[9]), 64'd0);
    check_value("odd_clusters_o[10]", 64'(odd_clusters_o[10]), 64'd0);
    check_value("odd_clusters_o[2]", 64'(odd_clusters_o[2]), 64'd1);
    compare_outputs();
endtask

task automatic boundary_touch_check();
    load_round(4'b0000, 3'b000);
    load_round(4'b0001, 3'b000);  // unit 4 in column 0
    load_round(4'b0000, 3'b000);
    grow_steps(1);
    merge_until_idle();
    check_value("odd_clusters_o[4]", 64'(odd_clusters_o[4]), 64'd1);
    compare_outputs();
    grow_steps(1);  // west link now full
    merge_until_idle();
    check_value("odd_clusters_o[4]", 64'(odd_clusters_o[4]), 64'd0);
    compare_outputs();
endtask

task automatic erasure_preload();
    load_round(4'b0000, 3'b000);
    load_round(4'b0000, 3'b000);
    load_round(4'b0110, 3'b010);  // link between columns 1 and 2 erased
    merge_until_idle();
    check_value("roots_o[10]", 64'(root_at(10)), 64'd9);
    check_value("odd_clusters_o", 64'(odd_clusters_o), 64'd0);
    compare_outputs();
    load_round(4'b0011, 3'b001);
    merge_until_idle();
    check_value("roots_o[6]", 64'(root_at(6)), 64'd5);  // moved down a round
    check_value("roots_o[9]", 64'(root_at(9)), 64'd8);
    check_value("odd_clusters_o", 64'(odd_clusters_o), 64'd0);
    compare_outputs();
endtask

task automatic random_rounds();
    int unsigned r;
    repeat (10) begin
        r = lcg_next();
        load_round(r[3:0], r[10:8]);
        grow_steps(2);
        merge_until_idle();
        compare_outputs();
    end
endtask

//--- testbench/tb_decoding_graph.sv
`timescale 1ns/1ns

module tb_decoding_graph;

    localparam int X  = decoder_pkg::GRID_WIDTH_X;
    localparam int U  = decoder_pkg::GRID_WIDTH_U;
    localparam int RL = decoder_pkg::ROW_LINK_COUNT;
    localparam int AW = decoder_pkg::ADDRESS_WIDTH;
    localparam int W  = int'(decoder_pkg::LINK_WEIGHT);
    localparam int CYCLE_LIMIT = 4000;  // six tests of up to 400 cycles with margin

    logic                       clk;
    logic                       rst_n_i;
    decoder_pkg::stage_t        global_stage;
    decoder_pkg::round_bits_t   measurements;
    decoder_pkg::erasure_bits_t erasure;
    decoder_pkg::pu_bits_t      odd_clusters_o;
    decoder_pkg::root_vec_t     roots_o;
    logic                       busy_o;

    // reference model state
    decoder_pkg::pu_bits_t      ref_defects;
    decoder_pkg::erasure_bits_t ref_erased [U];
    int ref_row_cnt   [U*RL];
    int ref_round_cnt [decoder_pkg::ROUND_LINK_COUNT];
    int ref_root      [decoder_pkg::PU_COUNT];  // as held by the units
    int ref_parent    [decoder_pkg::PU_COUNT];  // union-find scratch

    int unsigned lcg_state;
    int          cycle_count = 0;

    decoding_graph u_dut (
        .clk            (clk),
        .rst_n_i        (rst_n_i),
        .global_stage_i (global_stage),
        .measurements_i (measurements),
        .erasure_i      (erasure),
        .odd_clusters_o (odd_clusters_o),
        .roots_o        (roots_o),
        .busy_o         (busy_o)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("timeout: the run went past %0d clock cycles", CYCLE_LIMIT);
            $display("TESTBENCH FAILED");
            $fatal(1, "timeout");
        end
    end

    function automatic void clear_state();
        ref_defects = '0;
        for (int k = 0; k < U; k++) begin
            ref_erased[k] = '0;
        end
        for (int l = 0; l < U*RL; l++) begin
            ref_row_cnt[l] = 0;
        end
        for (int l = 0; l < decoder_pkg::ROUND_LINK_COUNT; l++) begin
            ref_round_cnt[l] = 0;
        end
        for (int p = 0; p < decoder_pkg::PU_COUNT; p++) begin
            ref_root[p] = p;
        end
    endfunction

    // every round moves down and new data enters on top
    function automatic void shift_in_round(
        input decoder_pkg::round_bits_t   meas,
        input decoder_pkg::erasure_bits_t er
    );
        for (int k = 0; k < U - 1; k++) begin
            ref_defects[k*X +: X] = ref_defects[(k+1)*X +: X];
            ref_erased[k]         = ref_erased[k+1];
        end
        ref_defects[(U-1)*X +: X] = meas;
        ref_erased[U-1]           = er;
        for (int k = 0; k < U; k++) begin
            for (int j = 0; j < RL; j++) begin
                ref_row_cnt[k*RL + j] = 0;
                if (j > 0 && j < X && ref_erased[k][j-1]) begin
                    ref_row_cnt[k*RL + j] = W;  // erased link starts full
                end
            end
        end
        for (int l = 0; l < decoder_pkg::ROUND_LINK_COUNT; l++) begin
            ref_round_cnt[l] = 0;
        end
        for (int p = 0; p < decoder_pkg::PU_COUNT; p++) begin
            ref_root[p] = p;
        end
    endfunction

    function automatic bit touches(input int p);
        int k;
        int i;
        k = p / X;
        i = p % X;
        return (i == 0 && ref_row_cnt[k*RL] == W) || (i == X - 1 && ref_row_cnt[k*RL + X] == W);
    endfunction

    // odd parity and no boundary in the whole cluster
    function automatic decoder_pkg::pu_bits_t odd_flags();
        decoder_pkg::pu_bits_t odd;
        bit parity;
        bit touch;
        for (int p = 0; p < decoder_pkg::PU_COUNT; p++) begin
            parity = 1'b0;
            touch  = 1'b0;
            for (int q = 0; q < decoder_pkg::PU_COUNT; q++) begin
                if (ref_root[q] == ref_root[p]) begin
                    parity = parity ^ ref_defects[q];
                    touch  = touch | touches(q);
                end
            end
            odd[p] = parity && !touch;
        end
        return odd;
    endfunction

    function automatic void grow_links();
        decoder_pkg::pu_bits_t odd;
        int n;
        odd = odd_flags();
        for (int k = 0; k < U; k++) begin
            for (int j = 0; j < RL; j++) begin
                n = 0;
                if (j > 0 && odd[k*X + j - 1]) n++;  // west endpoint
                if (j < X && odd[k*X + j]) n++;
                ref_row_cnt[k*RL + j] = (ref_row_cnt[k*RL + j] + n > W) ?
                                        W : ref_row_cnt[k*RL + j] + n;
            end
        end
        for (int l = 0; l < decoder_pkg::ROUND_LINK_COUNT; l++) begin
            n = 0;
            if (odd[l]) n++;
            if (odd[l + X]) n++;
            ref_round_cnt[l] = (ref_round_cnt[l] + n > W) ? W : ref_round_cnt[l] + n;
        end
    endfunction

    function automatic int find_set(input int p);
        int r;
        r = p;
        while (ref_parent[r] != r) r = ref_parent[r];
        return r;
    endfunction

    // smaller representative wins, so a set's root is its lowest address
    function automatic void join_sets(input int a, input int b);
        int ra;
        int rb;
        ra = find_set(a);
        rb = find_set(b);
        if (ra < rb) ref_parent[rb] = ra;
        else ref_parent[ra] = rb;
    endfunction

    function automatic void merge_clusters();
        for (int p = 0; p < decoder_pkg::PU_COUNT; p++) begin
            ref_parent[p] = p;
        end
        for (int k = 0; k < U; k++) begin
            for (int i = 1; i < X; i++) begin
                if (ref_row_cnt[k*RL + i] == W) join_sets(k*X + i - 1, k*X + i);
            end
        end
        for (int l = 0; l < decoder_pkg::ROUND_LINK_COUNT; l++) begin
            if (ref_round_cnt[l] == W) join_sets(l, l + X);
        end
        for (int p = 0; p < decoder_pkg::PU_COUNT; p++) begin
            ref_root[p] = find_set(p);
        end
    endfunction

    function automatic decoder_pkg::root_vec_t packed_roots();
        decoder_pkg::root_vec_t r;
        for (int p = 0; p < decoder_pkg::PU_COUNT; p++) begin
            r[p*AW +: AW] = decoder_pkg::addr_t'(ref_root[p]);
        end
        return r;
    endfunction

    `include "tb_tasks.svh"

    initial begin
        rst_n_i      = 1'b0;
        global_stage = decoder_pkg::STAGE_IDLE;
        measurements = '0;
        erasure      = '0;
        lcg_state    = 32'd19421;
        clear_state();
        repeat (4) @(negedge clk);
        rst_n_i = 1'b1;

        after_reset_check();
        load_and_shift();
        growth_and_merge();
        boundary_touch_check();
        erasure_preload();
        random_rounds();

        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule
